// File: dummy_pkg.sv
// --------------------------------------------------------------------------
// Dummy instruction inserter shared definitions. Holds the data types, the
// configuration register map, the RISC-V encodings of the dummy forms and
// the LFSR feedback mask
// --------------------------------------------------------------------------
`default_nettype none

package dummy_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  dummy_freq_t;
  typedef logic [6:0]  gap_t;
  typedef logic [3:0]  axil_addr_t;

  // The bus address carries one bit above the register window
  localparam int unsigned AXIL_ADDR_W = 5;

  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    word_t                  wdata;
    logic                   bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic        dummy_en;
    dummy_freq_t freq;
  } dummy_cfg_t;

  // One strobe per LFSR, bit 0 selects LFSR0
  typedef struct packed {
    logic [2:0] we;
    word_t      seed;
  } seed_wr_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
    logic   dummy;
    word_t  operand_a;
    word_t  operand_b;
  } issue_t;

  localparam axil_addr_t ADDR_CPUCTRL = 4'h0;
  localparam axil_addr_t ADDR_SEED0   = 4'h4;
  localparam axil_addr_t ADDR_SEED1   = 4'h8;
  localparam axil_addr_t ADDR_SEED2   = 4'hC;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_AND = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  localparam reg_addr_t REG_X0 = 5'd0;

  localparam word_t LFSR_TAPS = 32'h8000_0057;

endpackage

`default_nettype wire

// File: axil_cfg_regs.sv
// --------------------------------------------------------------------------
// AXI4-Lite write slave for the dummy inserter. Decodes the control
// register and the three seed registers, one write outstanding at a time
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axil_cfg_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dummy_pkg::axil_wr_req_t cfg_req,
  output dummy_pkg::axil_wr_rsp_t cfg_rsp,
  output dummy_pkg::dummy_cfg_t   cfg,
  output dummy_pkg::seed_wr_t     seed_wr
);

  import dummy_pkg::*;

  logic       accept;
  logic       in_window;
  logic       known;
  logic       ctrl_we;
  logic [2:0] seed_sel;
  axil_addr_t offset;

  logic       bvalid_q;
  logic [1:0] bresp_q;
  dummy_cfg_t cfg_q;

  // Address and data must arrive together, and the previous response must be gone
  assign accept = cfg_req.awvalid && cfg_req.wvalid && !bvalid_q;

  assign offset    = axil_addr_t'(cfg_req.awaddr[$bits(axil_addr_t)-1:0]);
  assign in_window = (cfg_req.awaddr[AXIL_ADDR_W-1:$bits(axil_addr_t)] == '0);

  always_comb begin
    known    = 1'b0;
    seed_sel = 3'b000;
    case (offset)
      ADDR_CPUCTRL: known = 1'b1;
      ADDR_SEED0: begin
        known    = 1'b1;
        seed_sel = 3'b001;
      end
      ADDR_SEED1: begin
        known    = 1'b1;
        seed_sel = 3'b010;
      end
      ADDR_SEED2: begin
        known    = 1'b1;
        seed_sel = 3'b100;
      end
      default: ;
    endcase
    // Anything outside the 16-byte window is an error and writes nothing
    if (!in_window) begin
      known    = 1'b0;
      seed_sel = 3'b000;
    end
  end

  assign ctrl_we = accept && known && (offset == ADDR_CPUCTRL);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      cfg_q    <= '0;
    end else begin
      if (accept) begin
        bvalid_q <= 1'b1;
      end else if (cfg_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ctrl_we) begin
        cfg_q.dummy_en <= cfg_req.wdata[0];
        cfg_q.freq     <= cfg_req.wdata[7:4];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      bresp_q <= known ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign cfg_rsp.awready = accept;
  assign cfg_rsp.wready  = accept;
  assign cfg_rsp.bvalid  = bvalid_q;
  assign cfg_rsp.bresp   = bresp_q;

  assign cfg = cfg_q;

  // The LFSR loads the seed at the edge that ends the accepting cycle
  assign seed_wr.we   = accept ? seed_sel : 3'b000;
  assign seed_wr.seed = cfg_req.wdata;

endmodule

`default_nettype wire

// File: lfsr_reg.sv
// --------------------------------------------------------------------------
// One 32-bit Galois LFSR with seed load. Falls back to its default seed
// whenever the next state would be the all-zero lockup state
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module lfsr_reg #(
  parameter dummy_pkg::word_t RESET_SEED = 32'h0000_0001
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             advance,
  input  logic             seed_we,
  input  dummy_pkg::word_t seed,
  output dummy_pkg::word_t value
);

  import dummy_pkg::*;

  word_t lfsr_q;
  word_t step;
  word_t candidate;
  word_t lfsr_d;

  // Right shift, with the feedback mask applied when a one falls out
  assign step = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

  always_comb begin
    if (seed_we) begin
      candidate = seed;
    end else if (advance) begin
      candidate = step;
    end else begin
      candidate = lfsr_q;
    end
  end

  // Zero would never leave zero again, so recover to the default seed
  assign lfsr_d = (candidate == '0) ? RESET_SEED : candidate;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lfsr_q <= RESET_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  assign value = lfsr_q;

endmodule

`default_nettype wire

// File: dummy_scheduler.sv
// --------------------------------------------------------------------------
// Dummy scheduler. Loads a random gap from LFSR0 and counts issued normal
// instructions down to zero, where it asks for a dummy
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dummy_scheduler (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dummy_pkg::dummy_cfg_t cfg,
  input  dummy_pkg::word_t      lfsr0,
  input  logic                  issue_fire,
  input  logic                  issue_is_dummy,
  output logic                  dummy_due
);

  import dummy_pkg::*;

  dummy_cfg_t cfg_q;
  gap_t       count_q;
  gap_t       gap_mask;
  gap_t       new_gap;
  logic       cfg_changed;
  logic       normal_fire;
  logic       reload;

  // N is a power of two, so the modulo is a mask of N-1
  always_comb begin
    if (cfg.freq[3]) begin
      gap_mask = gap_t'(63);
    end else if (cfg.freq[2]) begin
      gap_mask = gap_t'(31);
    end else if (cfg.freq[1]) begin
      gap_mask = gap_t'(15);
    end else if (cfg.freq[0]) begin
      gap_mask = gap_t'(7);
    end else begin
      gap_mask = gap_t'(3);
    end
  end

  assign new_gap = (gap_t'(lfsr0[5:0]) & gap_mask) + gap_t'(1);

  assign normal_fire = issue_fire && !issue_is_dummy;
  assign cfg_changed = (cfg != cfg_q);

  // Enabling or retuning restarts the gap, as does every issued dummy
  assign reload = cfg.dummy_en && (cfg_changed || (issue_fire && issue_is_dummy));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      count_q <= '0;
    end else begin
      cfg_q <= cfg;
      if (reload) begin
        // A normal word issued in the enabling cycle already uses up one slot
        count_q <= new_gap - (normal_fire ? gap_t'(1) : gap_t'(0));
      end else if (normal_fire && count_q != '0) begin
        count_q <= count_q - gap_t'(1);
      end
    end
  end

  assign dummy_due = cfg.dummy_en && !cfg_changed && (count_q == '0);

endmodule

`default_nettype wire

// File: dummy_issue_stage.sv
// --------------------------------------------------------------------------
// Issue stage. One output register that takes either the fetched word or a
// dummy built from LFSR0, with LFSR1 and LFSR2 as its operands
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dummy_issue_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  dummy_pkg::fetch_t fetch_in,
  output logic              fetch_ready,
  input  logic              dummy_due,
  input  dummy_pkg::word_t  lfsr0,
  input  dummy_pkg::word_t  lfsr1,
  input  dummy_pkg::word_t  lfsr2,
  output dummy_pkg::issue_t issue_out,
  input  logic              issue_ready,
  output logic              issue_fire,
  output logic              issue_is_dummy
);

  import dummy_pkg::*;

  issue_t     out_q;
  issue_t     out_d;
  instr_t     dummy_instr;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       can_load;
  logic       insert_dummy;
  logic       fetch_fire;
  logic       load_en;

  assign rs1 = lfsr0[6:2];
  assign rs2 = lfsr0[11:7];

  always_comb begin
    case (lfsr0[1:0])
      2'd0: begin
        opcode = OPCODE_OP;
        funct3 = FUNCT3_ADD;
        funct7 = FUNCT7_ADD;
      end
      2'd1: begin
        opcode = OPCODE_OP;
        funct3 = FUNCT3_AND;
        funct7 = FUNCT7_AND;
      end
      2'd2: begin
        opcode = OPCODE_OP;
        funct3 = FUNCT3_MUL;
        funct7 = FUNCT7_MUL;
      end
      default: begin
        // BLTU with a zero immediate, which leaves all imm fields clear
        opcode = OPCODE_BRANCH;
        funct3 = FUNCT3_BLTU;
        funct7 = 7'b0000000;
      end
    endcase
  end

  // R-type layout; for the branch, rd sits where imm[4:1|11] would be
  assign dummy_instr = {funct7, rs2, rs1, funct3, REG_X0, opcode};

  assign can_load     = !out_q.valid || issue_ready;
  assign insert_dummy = dummy_due && can_load;
  assign fetch_ready  = can_load && !dummy_due;
  assign fetch_fire   = fetch_in.valid && fetch_ready;
  assign load_en      = insert_dummy || fetch_fire;

  // Operands only mean something on a dummy entry
  always_comb begin
    out_d.valid     = 1'b1;
    out_d.dummy     = insert_dummy;
    out_d.instr     = insert_dummy ? dummy_instr : fetch_in.instr;
    out_d.operand_a = lfsr1;
    out_d.operand_b = lfsr2;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      out_q.valid <= 1'b0;
    end else if (load_en) begin
      out_q <= out_d;
    end else if (issue_ready) begin
      out_q.valid <= 1'b0;
    end
  end

  assign issue_out      = out_q;
  assign issue_fire     = load_en;
  assign issue_is_dummy = insert_dummy;

endmodule

`default_nettype wire

// File: dummy_insert_top.sv
// --------------------------------------------------------------------------
// Dummy instruction inserter top level. Ties the AXI4-Lite configuration,
// the three LFSRs, the scheduler and the issue stage together
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module dummy_insert_top #(
  parameter dummy_pkg::word_t LFSR0_SEED = 32'h0000_0001,
  parameter dummy_pkg::word_t LFSR1_SEED = 32'h0000_0002,
  parameter dummy_pkg::word_t LFSR2_SEED = 32'h0000_0003
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dummy_pkg::axil_wr_req_t cfg_req,
  output dummy_pkg::axil_wr_rsp_t cfg_rsp,
  input  dummy_pkg::fetch_t       fetch_in,
  output logic                    fetch_ready,
  output dummy_pkg::issue_t       issue_out,
  input  logic                    issue_ready
);

  import dummy_pkg::*;

  dummy_cfg_t cfg;
  seed_wr_t   seed_wr;
  word_t      lfsr0;
  word_t      lfsr1;
  word_t      lfsr2;
  logic       dummy_due;
  logic       issue_fire;
  logic       issue_is_dummy;

  axil_cfg_regs i_cfg_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cfg_req (cfg_req),
    .cfg_rsp (cfg_rsp),
    .cfg     (cfg),
    .seed_wr (seed_wr)
  );

  // All three step together, once per dummy that loads into the output register
  lfsr_reg #(.RESET_SEED(LFSR0_SEED)) i_lfsr0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .advance (issue_is_dummy),
    .seed_we (seed_wr.we[0]),
    .seed    (seed_wr.seed),
    .value   (lfsr0)
  );

  lfsr_reg #(.RESET_SEED(LFSR1_SEED)) i_lfsr1 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .advance (issue_is_dummy),
    .seed_we (seed_wr.we[1]),
    .seed    (seed_wr.seed),
    .value   (lfsr1)
  );

  lfsr_reg #(.RESET_SEED(LFSR2_SEED)) i_lfsr2 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .advance (issue_is_dummy),
    .seed_we (seed_wr.we[2]),
    .seed    (seed_wr.seed),
    .value   (lfsr2)
  );

  dummy_scheduler i_scheduler (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg            (cfg),
    .lfsr0          (lfsr0),
    .issue_fire     (issue_fire),
    .issue_is_dummy (issue_is_dummy),
    .dummy_due      (dummy_due)
  );

  dummy_issue_stage i_issue_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_in       (fetch_in),
    .fetch_ready    (fetch_ready),
    .dummy_due      (dummy_due),
    .lfsr0          (lfsr0),
    .lfsr1          (lfsr1),
    .lfsr2          (lfsr2),
    .issue_out      (issue_out),
    .issue_ready    (issue_ready),
    .issue_fire     (issue_fire),
    .issue_is_dummy (issue_is_dummy)
  );

endmodule

`default_nettype wire

// File: tb_dummy_insert_properties.sv
// ----------------------------------------------------------------------------
// Assertions bound into the issue stage. Output stability under
// back-pressure and the legal encodings of a dummy instruction
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dummy_insert_properties (
  input logic              clk_i,
  input logic              rst_ni,
  input dummy_pkg::issue_t issue_out,
  input logic              issue_ready
);

  import dummy_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal_form;

  assign opcode = issue_out.instr[6:0];
  assign funct3 = issue_out.instr[14:12];
  assign funct7 = issue_out.instr[31:25];

  // ADD, AND, MUL or BLTU and nothing else
  assign legal_form =
      (opcode == OPCODE_OP && funct7 == FUNCT7_ADD && funct3 == FUNCT3_ADD) ||
      (opcode == OPCODE_OP && funct7 == FUNCT7_AND && funct3 == FUNCT3_AND) ||
      (opcode == OPCODE_OP && funct7 == FUNCT7_MUL && funct3 == FUNCT3_MUL) ||
      (opcode == OPCODE_BRANCH && funct3 == FUNCT3_BLTU);

  hold_under_backpressure: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (issue_out.valid && !issue_ready) |=> $stable(issue_out))
    else $error("issue_out changed while stalled");

  dummy_form: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (issue_out.valid && issue_out.dummy) |-> (legal_form && issue_out.instr[11:7] == REG_X0))
    else $error("dummy has an illegal encoding");

  // For BLTU the immediate lives in bits 31:25 and 11:7
  bltu_zero_imm: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (issue_out.valid && issue_out.dummy && opcode == OPCODE_BRANCH) |->
      (funct7 == 7'b0000000 && issue_out.instr[11:7] == 5'd0))
    else $error("BLTU dummy has a nonzero offset");

endmodule

bind dummy_issue_stage tb_dummy_insert_properties i_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .issue_out   (issue_out),
  .issue_ready (issue_ready)
);

`default_nettype wire

// File: tb_dummy_insert.sv
// ----------------------------------------------------------------------------
// Testbench for the dummy instruction inserter. Runs the commands of the
// stimulus file against the DUT and checks order, gaps and dummy operands
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_dummy_insert;

  import dummy_pkg::*;

  localparam word_t SEED1_DEFAULT = 32'h0000_0002;
  localparam word_t SEED2_DEFAULT = 32'h0000_0003;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  axil_wr_req_t cfg_req;
  axil_wr_rsp_t cfg_rsp;
  fetch_t       fetch_in;
  logic         fetch_ready;
  issue_t       issue_out;
  logic         issue_ready;

  integer      seed = 11;
  int          cycles = 0;
  int          cycle_limit = 1000000;
  string       test_name = "reset";
  instr_t      next_sent = 32'h0000_1000;
  instr_t      next_expected = 32'h0000_1000;
  int          sent = 0;
  int          received = 0;
  int          run_len = 0;
  logic        model_en = 1'b0;
  dummy_freq_t model_freq = '0;
  word_t       last_a;
  word_t       last_b;
  word_t       dummy_a_q[$];
  word_t       dummy_b_q[$];

  dummy_insert_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_req     (cfg_req),
    .cfg_rsp     (cfg_rsp),
    .fetch_in    (fetch_in),
    .fetch_ready (fetch_ready),
    .issue_out   (issue_out),
    .issue_ready (issue_ready)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      report_failure($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (exp !== act) begin
      report_failure($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      report_failure($sformatf("MISMATCH %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  // Largest number of normal instructions allowed between two dummies
  function automatic int gap_limit(input dummy_freq_t freq);
    if (freq[3]) return 64;
    if (freq[2]) return 32;
    if (freq[1]) return 16;
    if (freq[0]) return 8;
    return 4;
  endfunction

  function automatic word_t lfsr_next(input word_t v, input word_t dflt);
    word_t n;
    n = v >> 1;
    if (v[0]) n = n ^ 32'h8000_0057;
    return (n == 32'h0) ? dflt : n;
  endfunction

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      report_failure($sformatf("Timeout after %0d cycles in test %s", cycles, test_name));
    end
  end

  always @(posedge clk_i) begin
    #2 issue_ready <= (($random(seed) & 3) != 0);
  end

  // Everything is stable at the falling edge, and a transfer then happens at the next rise
  always @(negedge clk_i) begin
    if (rst_ni && issue_out.valid && issue_ready) begin
      if (issue_out.dummy) begin
        if (!model_en) begin
          report_failure($sformatf("Dummy issued while disabled in test %s", test_name));
        end
        dummy_a_q.push_back(issue_out.operand_a);
        dummy_b_q.push_back(issue_out.operand_b);
        run_len = 0;
      end else begin
        check_instr(test_name, next_expected, issue_out.instr);
        next_expected = next_expected + 32'd1;
        received = received + 1;
        run_len = run_len + 1;
        if (model_en && run_len > gap_limit(model_freq)) begin
          report_failure($sformatf("Run of %0d normal instructions too long in test %s",
                                   run_len, test_name));
        end
      end
    end
  end

  task automatic send_words(input int count);
    logic fired;
    for (int i = 0; i < count; i++) begin
      fetch_in.valid = 1'b1;
      fetch_in.instr = next_sent;
      fired = 1'b0;
      while (!fired) begin
        @(negedge clk_i);
        fired = fetch_ready;
        @(posedge clk_i);
        #2;
      end
      next_sent = next_sent + 32'd1;
      sent = sent + 1;
    end
    fetch_in.valid = 1'b0;
  endtask

  task automatic drain;
    repeat (2) @(negedge clk_i);
    while (issue_out.valid || received != sent) @(negedge clk_i);
    @(posedge clk_i);
    #2;
  endtask

  task automatic axil_write(input axil_addr_t off, input word_t data, input logic [1:0] resp,
                            input logic wide);
    logic done;
    cfg_req.awvalid = 1'b1;
    cfg_req.wvalid  = 1'b1;
    cfg_req.awaddr  = {wide, off};
    cfg_req.wdata   = data;
    cfg_req.bready  = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = cfg_rsp.awready && cfg_rsp.wready;
      @(posedge clk_i);
      #2;
    end
    cfg_req.awvalid = 1'b0;
    cfg_req.wvalid  = 1'b0;
    @(negedge clk_i);
    if (!cfg_rsp.bvalid) report_failure($sformatf("No write response in test %s", test_name));
    check_resp(test_name, resp, cfg_rsp.bresp);
    @(posedge clk_i);
    #2;
    drain();
    // The model follows the control register once the pipeline is empty
    if (!wide && off == ADDR_CPUCTRL && resp == RESP_OKAY) begin
      model_en   = data[0];
      model_freq = data[7:4];
    end
    run_len = 0;
    dummy_a_q.delete();
    dummy_b_q.delete();
  endtask

  task automatic expect_dummy(input word_t exp_a, input word_t exp_b);
    while (dummy_a_q.size() == 0) begin
      send_words(1);
      drain();
    end
    check_word(test_name, exp_a, dummy_a_q.pop_front());
    check_word(test_name, exp_b, dummy_b_q.pop_front());
    last_a = exp_a;
    last_b = exp_b;
  endtask

  initial begin
    int    fd;
    int    total;
    string line;
    string cmd;
    string name;
    word_t a;
    word_t b;
    word_t c;
    rst_ni      = 1'b0;
    cfg_req     = '0;
    fetch_in    = '0;
    issue_ready = 1'b0;
    total       = 0;
    fd = $fopen("dummy_stimulus.txt", "r");
    if (fd == 0) report_failure("Cannot open the stimulus file dummy_stimulus.txt");
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%s %s %d", name, cmd, a) >= 2 && name[0] != "#") begin
        if (cmd == "SEND") total = total + int'(a);
        else if (cmd == "WR") total = total + 1;
        else total = total + 64;
      end
    end
    $fclose(fd);
    cycle_limit = 20 * total;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    fd = $fopen("dummy_stimulus.txt", "r");
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%s %s", name, cmd) == 2 && name[0] != "#") begin
        test_name = name;
        if (cmd == "WR") begin
          void'($sscanf(line, "%s %s %h %h %h", name, cmd, a, b, c));
          axil_write(axil_addr_t'(a[3:0]), b, c[1:0], a[4]);
        end else if (cmd == "SEND") begin
          void'($sscanf(line, "%s %s %d", name, cmd, a));
          send_words(int'(a));
          drain();
        end else if (cmd == "EXPECT_DUMMY") begin
          void'($sscanf(line, "%s %s %h %h", name, cmd, a, b));
          expect_dummy(a, b);
        end else if (cmd == "EXPECT_NEXT") begin
          expect_dummy(lfsr_next(last_a, SEED1_DEFAULT), lfsr_next(last_b, SEED2_DEFAULT));
        end else begin
          report_failure($sformatf("Unknown command %s in stimulus file", cmd));
        end
      end
    end
    $fclose(fd);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dummy_stimulus.txt
# Columns: test_name command arguments (hex unless noted)
# WR offset data bresp | SEND count(decimal) | EXPECT_DUMMY operand_a operand_b | EXPECT_NEXT
t1_reset_passthrough SEND 40
t2_known_offsets WR 00 00000000 0
t2_known_offsets WR 04 00000005 0
t2_known_offsets WR 08 00000007 0
t2_known_offsets WR 0C 00000009 0
t2_bad_offset WR 10 00000001 2
t2_bad_offset SEND 20
t3_freq_none WR 00 00000001 0
t3_freq_none SEND 120
t3_freq_bit0 WR 00 00000011 0
t3_freq_bit0 SEND 150
t3_freq_bit1 WR 00 00000021 0
t3_freq_bit1 SEND 200
t3_freq_bit2 WR 00 00000041 0
t3_freq_bit2 SEND 250
t3_freq_bit3 WR 00 00000081 0
t3_freq_bit3 SEND 300
t4_seed_operands WR 00 00000000 0
t4_seed_operands WR 08 12345678 0
t4_seed_operands WR 0C 9ABCDEF1 0
t4_seed_operands WR 00 00000011 0
t4_seed_operands EXPECT_DUMMY 12345678 9ABCDEF1
t4_seed_step EXPECT_NEXT
t4_seed_step2 EXPECT_NEXT
t5_zero_seed WR 00 00000000 0
t5_zero_seed WR 08 00000000 0
t5_zero_seed WR 0C 55AA55AA 0
t5_zero_seed WR 00 00000001 0
t5_zero_seed EXPECT_DUMMY 00000002 55AA55AA
t5_zero_seed_step EXPECT_NEXT
t6_random_ready WR 00 00000021 0
t6_random_ready SEND 300
t6_disable WR 00 00000000 0
t6_disable SEND 50

// File: vlog.f
dummy_pkg.sv
axil_cfg_regs.sv
lfsr_reg.sv
dummy_scheduler.sv
dummy_issue_stage.sv
dummy_insert_top.sv
tb_dummy_insert_properties.sv
tb_dummy_insert.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dummy inserter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dummy_insert \
  -f vlog.f -o vsim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/vsim > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }
